// ==== sources.f ====
common/umi_stream_pkg.sv
umi_stream/umi_stream_fifo.sv
umi_stream/umi_stream_chan.sv
rtl/umi_req_router.sv
rtl/umi_resp_arbiter.sv
rtl/umi_stream_top.sv
verif/umi_stream_properties.sv
verif/tb_umi_stream.sv

// ==== run.sh ====
#!/bin/sh
# Build the bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_umi_stream -f sources.f -o tb_umi_stream

# The run may stop early on a failed assertion, the log decides
./obj_dir/tb_umi_stream > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
   echo "run ok"
else
   echo "run FAILED"
   exit 1
fi

// ==== verif/tb_umi_stream.sv ====
//########################################
// Inputs change on the falling edge, checks sample on the rising edge
// Response lane is recovered from dstaddr, so requests carry it in srcaddr
//########################################

`timescale 1ns/1ps

module tb_umi_stream;

   localparam int NL = umi_stream_pkg::NLANE;
   localparam int LSB = umi_stream_pkg::LANE_LSB;
   // Well above the summed length of all tests
   localparam int TIMEOUT_CYCLES = 4000;

   logic                               umi_clk = 1'b0;
   logic                               umi_nreset;
   logic                               devicemode;
   logic                               umi_in_valid;
   umi_stream_pkg::umi_pkt_t           umi_in_pkt;
   logic                               umi_in_ready;
   logic                               umi_out_valid;
   umi_stream_pkg::umi_pkt_t           umi_out_pkt;
   logic                               umi_out_ready = 1'b1;
   logic [NL-1:0]                      usi_out_valid;
   umi_stream_pkg::usi_beat_t [NL-1:0] usi_out_beat;
   logic [NL-1:0]                      usi_out_ready = '1;
   logic [NL-1:0]                      usi_in_valid = '0;
   umi_stream_pkg::usi_beat_t [NL-1:0] usi_in_beat = '0;
   logic [NL-1:0]                      usi_in_ready;

   // Reference queues per lane
   umi_stream_pkg::usi_beat_t m2s_q [NL][$];
   umi_stream_pkg::usi_beat_t s2m_q [NL][$];
   umi_stream_pkg::umi_pkt_t  resp_q [NL][$];
   int served [NL];

   // Stimulus controls, changed only just after a rising edge
   logic          rand_ready = 1'b0;
   logic [NL-1:0] rdy_mask = '1;
   logic [NL-1:0] stream_mask = '0;
   logic [31:0]   lcg_state = 32'hfd9;
   logic [31:0]   rdy_rnd;
   logic [31:0]   beat_rnd;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int cycles = 0;
   int accepts;

   umi_stream_top dut (.*);

   always #2 umi_clk = ~umi_clk;

   function automatic logic [31:0] lcg();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [1:0] pick_lane();
      logic [31:0] r;
      r = lcg();
      return r[31:30];
   endfunction

   function automatic void log_error(input string msg);
      errors++;
      $display("ERR %0t: %s", $time, msg);
   endfunction

   // Random request, lane also placed in srcaddr for the response
   function automatic umi_stream_pkg::umi_pkt_t make_req(input umi_stream_pkg::umi_opcode_e opc,
                                                         input logic [1:0] lane);
      umi_stream_pkg::umi_pkt_t p;
      p.cmd = lcg();
      p.cmd[umi_stream_pkg::OPC_W-1:0] = opc;
      p.dstaddr = lcg();
      p.dstaddr[LSB +: 2] = lane;
      p.srcaddr = lcg();
      p.srcaddr[LSB +: 2] = lane;
      p.data = lcg();
      return p;
   endfunction

   //########################################
   // Reference model updates
   //########################################

   function automatic void take_request(input umi_stream_pkg::umi_pkt_t req);
      logic [1:0] l;
      umi_stream_pkg::umi_pkt_t rsp;
      umi_stream_pkg::usi_beat_t b;
      l = req.dstaddr[LSB +: 2];
      assert (devicemode || req.cmd[4:0] == umi_stream_pkg::UMI_REQ_POSTED)
      else log_error("non-posted request accepted in link mode");
      // Response: upper cmd copied, reply to srcaddr
      rsp.cmd = {req.cmd[31:5], umi_stream_pkg::UMI_RESP_WRITE};
      rsp.dstaddr = req.srcaddr;
      rsp.srcaddr = '0;
      rsp.data = '0;
      b.data = req.data;
      b.last = req.cmd[umi_stream_pkg::EOM_BIT];
      if (req.cmd[4:0] != umi_stream_pkg::UMI_REQ_READ)
         m2s_q[l].push_back(b);
      if (req.cmd[4:0] == umi_stream_pkg::UMI_REQ_WRITE)
         resp_q[l].push_back(rsp);
      if (req.cmd[4:0] == umi_stream_pkg::UMI_REQ_READ && s2m_q[l].size() > 0)
      begin
         b = s2m_q[l].pop_front();
         rsp.cmd[4:0] = umi_stream_pkg::UMI_RESP_READ;
         rsp.data = b.data;
         resp_q[l].push_back(rsp);
      end
   endfunction

   function automatic void check_out(input umi_stream_pkg::umi_pkt_t pkt);
      logic [1:0] l;
      umi_stream_pkg::umi_pkt_t want;
      umi_stream_pkg::usi_beat_t b;
      l = pkt.dstaddr[LSB +: 2];
      checks++;
      served[l]++;
      want = '0;
      if (devicemode)
      begin
         assert (resp_q[l].size() > 0) else log_error("response with nothing pending");
         if (resp_q[l].size() > 0)
            want = resp_q[l].pop_front();
      end
      else
      begin
         assert (s2m_q[l].size() > 0) else log_error("link packet with no stream beat");
         // Posted write to the lane base, EOM from last
         if (s2m_q[l].size() > 0)
            b = s2m_q[l].pop_front();
         want.cmd[4:0] = umi_stream_pkg::UMI_REQ_POSTED;
         want.cmd[umi_stream_pkg::EOM_BIT] = b.last;
         want.dstaddr[LSB +: 2] = l;
         want.data = b.data;
      end
      assert (pkt == want)
      else log_error($sformatf("lane %0d umi_out %h, expected %h", l, pkt, want));
   endfunction

   function automatic void check_stream(input int l, input umi_stream_pkg::usi_beat_t beat);
      umi_stream_pkg::usi_beat_t want;
      checks++;
      want = '0;
      assert (m2s_q[l].size() > 0) else log_error("stream beat with no write behind it");
      if (m2s_q[l].size() > 0)
         want = m2s_q[l].pop_front();
      assert (beat == want)
      else log_error($sformatf("lane %0d usi_out %h, expected %h", l, beat, want));
   endfunction

   // Pops before pushes, a FIFO never returns a beat written the same cycle
   always @(posedge umi_clk)
   begin
      if (umi_nreset)
      begin
         if (umi_in_valid && umi_in_ready)
            take_request(umi_in_pkt);
         if (umi_out_valid && umi_out_ready)
            check_out(umi_out_pkt);
         for (int l = 0; l < NL; l++)
         begin
            if (usi_out_valid[l] && usi_out_ready[l])
               check_stream(l, usi_out_beat[l]);
            if (usi_in_valid[l] && usi_in_ready[l])
               s2m_q[l].push_back(usi_in_beat[l]);
         end
      end
   end

   //########################################
   // Drivers
   //########################################

   // Ready patterns and random stream-in beats
   always @(negedge umi_clk)
   begin
      rdy_rnd = lcg();
      umi_out_ready = rand_ready ? rdy_rnd[31] : 1'b1;
      usi_out_ready = (rand_ready ? rdy_rnd[30 -: NL] : '1) & rdy_mask;
      for (int l = 0; l < NL; l++)
      begin
         beat_rnd = lcg();
         usi_in_valid[l] = stream_mask[l] & beat_rnd[31];
         usi_in_beat[l].data = lcg();
         usi_in_beat[l].last = beat_rnd[30];
      end
   end

   always @(posedge umi_clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("sim failed");
         $finish;
      end
   end

   // Returns at the rising edge that accepts the request
   task automatic send_req(input umi_stream_pkg::umi_opcode_e opc, input logic [1:0] lane);
      @(negedge umi_clk);
      umi_in_pkt = make_req(opc, lane);
      umi_in_valid = 1'b1;
      @(posedge umi_clk);
      while (!umi_in_ready)
         @(posedge umi_clk);
   endtask

   task automatic stop_req();
      @(negedge umi_clk);
      umi_in_valid = 1'b0;
      @(posedge umi_clk);
   endtask

   task automatic set_mode(input logic mode);
      @(negedge umi_clk);
      devicemode = mode;
      for (int l = 0; l < NL; l++)
         served[l] = 0;
      @(posedge umi_clk);
   endtask

   // Until every expected output has been seen
   task automatic wait_drain();
      int pend;
      pend = 1;
      while (pend != 0)
      begin
         @(negedge umi_clk);
         pend = 0;
         for (int l = 0; l < NL; l++)
            pend += m2s_q[l].size() + resp_q[l].size() + (devicemode ? 0 : s2m_q[l].size());
      end
      @(posedge umi_clk);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s done, %0d errors so far", tests, name, errors);
   endtask

   //########################################
   // Tests
   //########################################

   initial
   begin
      int nbeat [NL];
      logic [31:0] r;
      umi_nreset = 1'b0;
      devicemode = 1'b1;
      umi_in_valid = 1'b0;
      umi_in_pkt = '0;
      repeat (16) @(posedge umi_clk);
      @(negedge umi_clk);
      umi_nreset = 1'b1;
      @(posedge umi_clk);

      // Posted writes, random stream back-pressure
      rand_ready = 1'b1;
      repeat (24) send_req(umi_stream_pkg::UMI_REQ_POSTED, pick_lane());
      stop_req();
      wait_drain();
      end_test("posted writes");

      // Acked writes
      rand_ready = 1'b0;
      repeat (12) send_req(umi_stream_pkg::UMI_REQ_WRITE, pick_lane());
      stop_req();
      wait_drain();
      end_test("acked writes");

      // Fill stream-in FIFOs, then read every beat back
      stream_mask = '1;
      repeat (12) @(posedge umi_clk);
      stream_mask = '0;
      repeat (2) @(posedge umi_clk);
      @(negedge umi_clk);
      for (int l = 0; l < NL; l++)
         nbeat[l] = s2m_q[l].size();
      for (int l = 0; l < NL; l++)
         repeat (nbeat[l]) send_req(umi_stream_pkg::UMI_REQ_READ, 2'(l));
      // Lane 1 is empty now, the read waits for a beat
      fork
         send_req(umi_stream_pkg::UMI_REQ_READ, 2'd1);
         begin
            repeat (10)
            begin
               @(posedge umi_clk);
               assert (!(umi_in_valid && umi_in_ready))
               else log_error("read to an empty lane was accepted");
            end
            stream_mask = 4'b0010;
         end
      join
      stream_mask = '0;
      stop_req();
      wait_drain();
      end_test("reads");

      // Link mode, all lanes stream up
      set_mode(1'b0);
      rand_ready = 1'b1;
      stream_mask = '1;
      repeat (40) @(posedge umi_clk);
      stream_mask = '0;
      @(negedge umi_clk);
      umi_in_pkt = make_req(umi_stream_pkg::UMI_REQ_READ, pick_lane());
      umi_in_valid = 1'b1;
      repeat (50)
      begin
         @(posedge umi_clk);
         assert (!umi_in_ready) else log_error("read accepted in link mode");
      end
      stop_req();
      wait_drain();
      for (int l = 0; l < NL; l++)
         assert (served[l] > 0) else log_error($sformatf("lane %0d never served", l));
      end_test("link mode");

      // Blocked stream lane takes DEPTH posted writes
      set_mode(1'b1);
      rand_ready = 1'b0;
      rdy_mask = 4'b1011;
      accepts = 0;
      @(negedge umi_clk);
      umi_in_pkt = make_req(umi_stream_pkg::UMI_REQ_POSTED, 2'd2);
      umi_in_valid = 1'b1;
      repeat (12)
      begin
         @(posedge umi_clk);
         if (umi_in_valid && umi_in_ready)
            accepts++;
      end
      stop_req();
      assert (accepts == umi_stream_pkg::DEPTH)
      else log_error($sformatf("blocked lane took %0d writes", accepts));
      rdy_mask = '1;
      end_test("blocked lane");

      // Mixed traffic under random umi_out back-pressure
      rand_ready = 1'b1;
      stream_mask = '1;
      repeat (20)
      begin
         r = lcg();
         send_req(r[31] ? umi_stream_pkg::UMI_REQ_READ : umi_stream_pkg::UMI_REQ_WRITE, r[29:28]);
      end
      stream_mask = '0;
      stop_req();
      wait_drain();
      end_test("back-pressure");

      errors += dut.u_props.prop_fails;
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== verif/umi_stream_properties.sv ====
//########################################
// Bound into umi_stream_top, the bind below assumes NLANE is 4
// Stream-in occupancy follows the usi_in handshake and FIFO pops
//########################################

`timescale 1ns/1ps

module umi_stream_properties (
   input logic                                                   umi_clk,
   input logic                                                   umi_nreset,
   input logic                                                   umi_out_valid,
   input logic                                                   umi_out_ready,
   input umi_stream_pkg::umi_pkt_t                               umi_out_pkt,
   input logic [umi_stream_pkg::NLANE-1:0]                       usi_out_valid,
   input logic [umi_stream_pkg::NLANE-1:0]                       usi_out_ready,
   input umi_stream_pkg::usi_beat_t [umi_stream_pkg::NLANE-1:0]  usi_out_beat,
   input logic [umi_stream_pkg::NLANE-1:0]                       usi_in_valid,
   input logic [umi_stream_pkg::NLANE-1:0]                       usi_in_ready,
   input logic [umi_stream_pkg::NLANE-1:0]                       s2m_pop
);

   int prop_fails = 0;

   // Merged output holds still under back-pressure
   a_out_stable: assert property (@(posedge umi_clk) disable iff (!umi_nreset)
      umi_out_valid && !umi_out_ready |=> umi_out_valid && $stable(umi_out_pkt))
   else
   begin
      prop_fails++;
      $error("umi_out dropped valid or changed its packet while stalled");
   end

   // Nothing valid leaves while in reset
   a_reset_idle: assert property (@(posedge umi_clk)
      !umi_nreset |=> !umi_out_valid && (usi_out_valid == '0))
   else
   begin
      prop_fails++;
      $error("output valid seen right after reset");
   end

   for (genvar i = 0; i < umi_stream_pkg::NLANE; i++)
   begin : g_lane
      // Beats held in the stream-in FIFO
      logic [umi_stream_pkg::CNT_W-1:0] occ;
      logic                             push;

      assign push = usi_in_valid[i] & usi_in_ready[i];

      always_ff @(posedge umi_clk or negedge umi_nreset)
      begin
         if (!umi_nreset)
            occ <= '0;
         else if (push && !s2m_pop[i])
            occ <= occ + 1'b1;
         else if (s2m_pop[i] && !push)
            occ <= occ - 1'b1;
      end

      // Stream beat held under back-pressure
      a_usi_stable: assert property (@(posedge umi_clk) disable iff (!umi_nreset)
         usi_out_valid[i] && !usi_out_ready[i] |=> usi_out_valid[i] && $stable(usi_out_beat[i]))
      else
      begin
         prop_fails++;
         $error("usi_out lane %0d changed while stalled", i);
      end

      // Full stream-in FIFO refuses beats
      a_full_ready: assert property (@(posedge umi_clk) disable iff (!umi_nreset)
         occ == (umi_stream_pkg::CNT_W)'(umi_stream_pkg::DEPTH) |-> !usi_in_ready[i])
      else
      begin
         prop_fails++;
         $error("usi_in_ready high on full FIFO, lane %0d", i);
      end
   end

endmodule

bind umi_stream_top umi_stream_properties u_props (
   .umi_clk       (umi_clk),
   .umi_nreset    (umi_nreset),
   .umi_out_valid (umi_out_valid),
   .umi_out_ready (umi_out_ready),
   .umi_out_pkt   (umi_out_pkt),
   .usi_out_valid (usi_out_valid),
   .usi_out_ready (usi_out_ready),
   .usi_out_beat  (usi_out_beat),
   .usi_in_valid  (usi_in_valid),
   .usi_in_ready  (usi_in_ready),
   .s2m_pop       ({g_lane[3].u_chan.s2m_rd, g_lane[2].u_chan.s2m_rd,
                    g_lane[1].u_chan.s2m_rd, g_lane[0].u_chan.s2m_rd})
);

// ==== rtl/umi_stream_top.sv ====
//########################################
// Bridge top, all lanes on umi_clk
// devicemode is shared by every lane and is meant to be static
//########################################

`timescale 1ns/1ps

module umi_stream_top (
   input  logic                                                   umi_clk,
   input  logic                                                   umi_nreset,
   input  logic                                                   devicemode,
   // UMI request in
   input  logic                                                   umi_in_valid,
   input  umi_stream_pkg::umi_pkt_t                               umi_in_pkt,
   output logic                                                   umi_in_ready,
   // UMI out
   output logic                                                   umi_out_valid,
   output umi_stream_pkg::umi_pkt_t                               umi_out_pkt,
   input  logic                                                   umi_out_ready,
   // Stream lanes
   output logic [umi_stream_pkg::NLANE-1:0]                       usi_out_valid,
   output umi_stream_pkg::usi_beat_t [umi_stream_pkg::NLANE-1:0]  usi_out_beat,
   input  logic [umi_stream_pkg::NLANE-1:0]                       usi_out_ready,
   input  logic [umi_stream_pkg::NLANE-1:0]                       usi_in_valid,
   input  umi_stream_pkg::usi_beat_t [umi_stream_pkg::NLANE-1:0]  usi_in_beat,
   output logic [umi_stream_pkg::NLANE-1:0]                       usi_in_ready
);

   // Router to channels
   logic [umi_stream_pkg::NLANE-1:0]                     req_valid;
   logic [umi_stream_pkg::NLANE-1:0]                     req_ready;
   umi_stream_pkg::umi_pkt_t                             req_pkt;

   // Channels to arbiter
   logic [umi_stream_pkg::NLANE-1:0]                     chan_valid;
   logic [umi_stream_pkg::NLANE-1:0]                     chan_ready;
   umi_stream_pkg::umi_pkt_t [umi_stream_pkg::NLANE-1:0] chan_pkt;

   umi_req_router u_router (
      .umi_in_valid (umi_in_valid),
      .umi_in_pkt   (umi_in_pkt),
      .umi_in_ready (umi_in_ready),
      .lane_ready   (req_ready),
      .lane_valid   (req_valid),
      .lane_pkt     (req_pkt)
   );

   //########################################
   // Lanes
   //########################################

   for (genvar i = 0; i < umi_stream_pkg::NLANE; i++)
   begin : g_lane
      umi_stream_chan #(.LANE(i)) u_chan (
         .umi_clk       (umi_clk),
         .umi_nreset    (umi_nreset),
         .devicemode    (devicemode),
         .req_valid     (req_valid[i]),
         .req_pkt       (req_pkt),
         .req_ready     (req_ready[i]),
         .out_valid     (chan_valid[i]),
         .out_pkt       (chan_pkt[i]),
         .out_ready     (chan_ready[i]),
         .usi_out_valid (usi_out_valid[i]),
         .usi_out_beat  (usi_out_beat[i]),
         .usi_out_ready (usi_out_ready[i]),
         .usi_in_valid  (usi_in_valid[i]),
         .usi_in_beat   (usi_in_beat[i]),
         .usi_in_ready  (usi_in_ready[i])
      );
   end

   umi_resp_arbiter u_arbiter (
      .umi_clk       (umi_clk),
      .umi_nreset    (umi_nreset),
      .lane_valid    (chan_valid),
      .lane_pkt      (chan_pkt),
      .lane_ready    (chan_ready),
      .umi_out_valid (umi_out_valid),
      .umi_out_pkt   (umi_out_pkt),
      .umi_out_ready (umi_out_ready)
   );

endmodule

// ==== rtl/umi_resp_arbiter.sv ====
//########################################
// Round-robin merge of lane packets onto umi_out
// Grant locked while umi_out is stalled, lanes must hold their packet
//########################################

`timescale 1ns/1ps

module umi_resp_arbiter (
   input  logic                                                   umi_clk,
   input  logic                                                   umi_nreset,
   // Lane side
   input  logic [umi_stream_pkg::NLANE-1:0]                       lane_valid,
   input  umi_stream_pkg::umi_pkt_t [umi_stream_pkg::NLANE-1:0]   lane_pkt,
   output logic [umi_stream_pkg::NLANE-1:0]                       lane_ready,
   // Merged output
   output logic                                                   umi_out_valid,
   output umi_stream_pkg::umi_pkt_t                               umi_out_pkt,
   input  logic                                                   umi_out_ready
);

   // Search start, next lane after the last transfer
   logic [umi_stream_pkg::LANE_W-1:0] ptr;

   // Lock held across a stalled cycle
   logic                              hold;
   logic [umi_stream_pkg::LANE_W-1:0] hold_idx;

   // Round-robin search
   logic                              found;
   logic [umi_stream_pkg::LANE_W-1:0] cand;
   logic [umi_stream_pkg::LANE_W-1:0] pick;
   logic [umi_stream_pkg::LANE_W-1:0] sel;

   // First valid lane at or after ptr
   always_comb
   begin
      found = 1'b0;
      pick  = ptr;
      cand  = ptr;
      for (int k = 0; k < umi_stream_pkg::NLANE; k++)
      begin
         cand = (umi_stream_pkg::LANE_W)'((int'(ptr) + k) % umi_stream_pkg::NLANE);
         if (!found && lane_valid[cand])
         begin
            found = 1'b1;
            pick  = cand;
         end
      end
   end

   assign sel = hold ? hold_idx : pick;

   // Output mux and ready steering
   assign umi_out_valid = lane_valid[sel];
   assign umi_out_pkt   = lane_pkt[sel];

   always_comb
   begin
      lane_ready = '0;
      lane_ready[sel] = umi_out_ready;
   end

   always_ff @(posedge umi_clk or negedge umi_nreset)
   begin
      if (!umi_nreset)
      begin
         ptr      <= '0;
         hold     <= 1'b0;
         hold_idx <= '0;
      end
      else
      begin
         hold     <= umi_out_valid & ~umi_out_ready;
         hold_idx <= sel;
         // Pointer moves one past the lane just served
         if (umi_out_valid && umi_out_ready)
            ptr <= (umi_stream_pkg::LANE_W)'((int'(sel) + 1) % umi_stream_pkg::NLANE);
      end
   end

endmodule

// ==== rtl/umi_req_router.sv ====
//########################################
// Lane picked from dstaddr[LANE_LSB +: 2], no buffering
// Only the addressed lane sees valid, its ready comes back
//########################################

`timescale 1ns/1ps

module umi_req_router (
   // Incoming request
   input  logic                                   umi_in_valid,
   input  umi_stream_pkg::umi_pkt_t               umi_in_pkt,
   output logic                                   umi_in_ready,
   // Per-lane request side
   input  logic [umi_stream_pkg::NLANE-1:0]       lane_ready,
   output logic [umi_stream_pkg::NLANE-1:0]       lane_valid,
   output umi_stream_pkg::umi_pkt_t               lane_pkt
);

   // Decoded lane index
   logic [umi_stream_pkg::LANE_W-1:0] lane_sel;

   //########################################
   // Lane decode
   //########################################

   // Two address bits select the channel
   assign lane_sel = umi_in_pkt.dstaddr[umi_stream_pkg::LANE_LSB +: umi_stream_pkg::LANE_W];

   // One-hot valid toward the channels
   always_comb
   begin
      lane_valid = '0;
      lane_valid[lane_sel] = umi_in_valid;
   end

   //########################################
   // Handshake return
   //########################################

   // Ready of the addressed lane only
   // Other lanes stalling never blocks this request
   assign umi_in_ready = lane_ready[lane_sel];

   // Packet shared by all lanes, qualified by lane_valid
   assign lane_pkt = umi_in_pkt;

endmodule

// ==== umi_stream/umi_stream_chan.sv ====
//########################################
// One lane: device mode serves reads and writes, link mode posts beats
// Response slot holds one response, reads and acked writes stall behind it
//########################################

`timescale 1ns/1ps

module umi_stream_chan #(
   parameter int LANE = 0
) (
   input  logic                      umi_clk,
   input  logic                      umi_nreset,
   input  logic                      devicemode,
   // Request from router
   input  logic                      req_valid,
   input  umi_stream_pkg::umi_pkt_t  req_pkt,
   output logic                      req_ready,
   // Packet toward arbiter
   output logic                      out_valid,
   output umi_stream_pkg::umi_pkt_t  out_pkt,
   input  logic                      out_ready,
   // Stream lanes
   output logic                      usi_out_valid,
   output umi_stream_pkg::usi_beat_t usi_out_beat,
   input  logic                      usi_out_ready,
   input  logic                      usi_in_valid,
   input  umi_stream_pkg::usi_beat_t usi_in_beat,
   output logic                      usi_in_ready
);

   umi_stream_pkg::umi_opcode_e opcode;
   logic is_read;
   logic is_write;
   logic is_posted;

   // Handshake strobes
   logic req_accept;
   logic resp_take;
   logic resp_done;
   logic resp_valid;
   logic resp_stall;

   // Response slot
   umi_stream_pkg::resp_state_e resp_state;
   umi_stream_pkg::resp_state_e resp_next;
   umi_stream_pkg::umi_pkt_t    resp_pkt;
   umi_stream_pkg::umi_pkt_t    link_pkt;

   // FIFO hookup
   logic                      m2s_wr;
   logic                      m2s_full;
   logic                      m2s_empty;
   umi_stream_pkg::usi_beat_t m2s_beat;
   logic                      s2m_rd;
   logic                      s2m_full;
   logic                      s2m_empty;
   umi_stream_pkg::usi_beat_t s2m_beat;

   //########################################
   // Request decode
   //########################################

   assign opcode    = umi_stream_pkg::umi_opcode_e'(req_pkt.cmd[umi_stream_pkg::OPC_W-1:0]);
   assign is_read   = (opcode == umi_stream_pkg::UMI_REQ_READ);
   assign is_write  = (opcode == umi_stream_pkg::UMI_REQ_WRITE);
   assign is_posted = (opcode == umi_stream_pkg::UMI_REQ_POSTED);

   // Pending response not taken this cycle
   assign resp_valid = (resp_state != umi_stream_pkg::RESP_IDLE);
   assign resp_stall = resp_valid & ~out_ready;

   always_comb
   begin
      if (is_posted)
         req_ready = ~m2s_full;
      else if (is_write)
         req_ready = devicemode & ~m2s_full & ~resp_stall;
      else if (is_read)
         req_ready = devicemode & ~s2m_empty & ~resp_stall;
      else
         req_ready = 1'b0;
   end

   assign req_accept = req_valid & req_ready;
   assign resp_take  = req_accept & devicemode & (is_read | is_write);
   assign resp_done  = devicemode & resp_valid & out_ready;

   //########################################
   // Response slot
   //########################################

   always_comb
   begin
      case (resp_state)
         umi_stream_pkg::RESP_IDLE:
            resp_next = resp_take ? umi_stream_pkg::RESP_FRESH : umi_stream_pkg::RESP_IDLE;
         umi_stream_pkg::RESP_FRESH, umi_stream_pkg::RESP_HELD:
            if (resp_take)
               resp_next = umi_stream_pkg::RESP_FRESH;
            else if (resp_done)
               resp_next = umi_stream_pkg::RESP_IDLE;
            else
               resp_next = umi_stream_pkg::RESP_HELD;
         default:
            resp_next = umi_stream_pkg::RESP_IDLE;
      endcase
   end

   always_ff @(posedge umi_clk or negedge umi_nreset)
   begin
      if (!umi_nreset)
         resp_state <= umi_stream_pkg::RESP_IDLE;
      else
         resp_state <= resp_next;
   end

   // Response built from the request, read data from the s2m head
   always_ff @(posedge umi_clk)
   begin
      if (resp_take)
      begin
         resp_pkt.cmd <= req_pkt.cmd;
         resp_pkt.cmd[umi_stream_pkg::OPC_W-1:0] <= is_read ? umi_stream_pkg::UMI_RESP_READ :
                                                              umi_stream_pkg::UMI_RESP_WRITE;
         resp_pkt.dstaddr <= req_pkt.srcaddr;
         resp_pkt.srcaddr <= '0;
         resp_pkt.data    <= is_read ? s2m_beat.data : '0;
      end
   end

   //########################################
   // Link mode packet builder
   //########################################

   // Posted write to the lane base, EOM from last
   always_comb
   begin
      link_pkt = '0;
      link_pkt.cmd[umi_stream_pkg::OPC_W-1:0] = umi_stream_pkg::UMI_REQ_POSTED;
      link_pkt.cmd[umi_stream_pkg::EOM_BIT]   = s2m_beat.last;
      link_pkt.dstaddr[umi_stream_pkg::LANE_LSB +: umi_stream_pkg::LANE_W] =
         LANE[umi_stream_pkg::LANE_W-1:0];
      link_pkt.data = s2m_beat.data;
   end

   assign out_valid = devicemode ? resp_valid : ~s2m_empty;
   assign out_pkt   = devicemode ? resp_pkt : link_pkt;

   //########################################
   // FIFOs
   //########################################

   // Memory to stream, any accepted write
   assign m2s_wr        = req_accept & (is_write | is_posted);
   assign usi_out_valid = ~m2s_empty;

   umi_stream_fifo u_m2s_fifo (
      .umi_clk    (umi_clk),
      .umi_nreset (umi_nreset),
      .wr_en      (m2s_wr),
      .wr_beat    ({req_pkt.data, req_pkt.cmd[umi_stream_pkg::EOM_BIT]}),
      .full       (m2s_full),
      .rd_en      (usi_out_ready),
      .empty      (m2s_empty),
      .rd_beat    (m2s_beat)
   );

   assign usi_out_beat = m2s_beat;

   // Stream to memory, drained by reads or link transfers
   assign s2m_rd       = devicemode ? (resp_take & is_read) : (out_valid & out_ready);
   assign usi_in_ready = ~s2m_full;

   umi_stream_fifo u_s2m_fifo (
      .umi_clk    (umi_clk),
      .umi_nreset (umi_nreset),
      .wr_en      (usi_in_valid & usi_in_ready),
      .wr_beat    (usi_in_beat),
      .full       (s2m_full),
      .rd_en      (s2m_rd),
      .empty      (s2m_empty),
      .rd_beat    (s2m_beat)
   );

endmodule

// ==== umi_stream/umi_stream_fifo.sv ====
//########################################
// Synchronous FWFT FIFO of DEPTH stream beats
// Write while full only lands when a read happens the same cycle
//########################################

`timescale 1ns/1ps

module umi_stream_fifo (
   input  logic                      umi_clk,
   input  logic                      umi_nreset,
   // Write side
   input  logic                      wr_en,
   input  umi_stream_pkg::usi_beat_t wr_beat,
   output logic                      full,
   // Read side
   input  logic                      rd_en,
   output logic                      empty,
   output umi_stream_pkg::usi_beat_t rd_beat
);

   // Beat storage
   umi_stream_pkg::usi_beat_t mem [umi_stream_pkg::DEPTH];

   // Ring pointers and occupancy
   logic [umi_stream_pkg::PTR_W-1:0] wr_ptr;
   logic [umi_stream_pkg::PTR_W-1:0] rd_ptr;
   logic [umi_stream_pkg::CNT_W-1:0] count;

   // Qualified strobes
   logic do_wr;
   logic do_rd;

   assign full  = (count == (umi_stream_pkg::CNT_W)'(umi_stream_pkg::DEPTH));
   assign empty = (count == '0);

   assign do_rd = rd_en & ~empty;
   assign do_wr = wr_en & (~full | do_rd);

   // Head beat shown whenever not empty
   assign rd_beat = mem[rd_ptr];

   always_ff @(posedge umi_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_beat;
   end

   // Pointer wrap at DEPTH-1, count tracks the difference
   always_ff @(posedge umi_clk or negedge umi_nreset)
   begin
      if (!umi_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= (wr_ptr == (umi_stream_pkg::PTR_W)'(umi_stream_pkg::DEPTH - 1)) ?
                      '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == (umi_stream_pkg::PTR_W)'(umi_stream_pkg::DEPTH - 1)) ?
                      '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

endmodule

// ==== common/umi_stream_pkg.sv ====
//########################################
// Shared widths, lane count and UMI encodings for the stream bridge
// NLANE must be a power of two that fits the 2-bit lane select field
//########################################

package umi_stream_pkg;

   //########################################
   // Widths
   //########################################

   // UMI packet field widths
   localparam int AW = 32;
   localparam int CW = 32;
   localparam int DW = 32;

   // Lane select field in dstaddr
   localparam int NLANE    = 4;
   localparam int LANE_LSB = 12;
   localparam int LANE_W   = 2;

   // Stream FIFO sizing
   localparam int DEPTH = 4;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 1;

   // Command field positions
   localparam int OPC_W   = 5;
   localparam int EOM_BIT = 22;

   //########################################
   // Encodings
   //########################################

   // Standard UMI opcodes, low command bits
   typedef enum logic [OPC_W-1:0] {
      UMI_REQ_READ   = 5'd1,
      UMI_RESP_READ  = 5'd2,
      UMI_REQ_WRITE  = 5'd3,
      UMI_RESP_WRITE = 5'd4,
      UMI_REQ_POSTED = 5'd5
   } umi_opcode_e;

   // Channel response slot
   typedef enum logic [1:0] {
      RESP_IDLE,
      RESP_FRESH,
      RESP_HELD
   } resp_state_e;

   //########################################
   // Packets
   //########################################

   // Full UMI transaction, 128 bits
   typedef struct packed {
      logic [CW-1:0] cmd;
      logic [AW-1:0] dstaddr;
      logic [AW-1:0] srcaddr;
      logic [DW-1:0] data;
   } umi_pkt_t;

   // One stream beat, data plus end flag
   typedef struct packed {
      logic [DW-1:0] data;
      logic          last;
   } usi_beat_t;

endpackage
